//--- execute_stage_defs.svh
`ifndef EXECUTE_STAGE_DEFS_SVH
`define EXECUTE_STAGE_DEFS_SVH

// ==============================
// Execute stage sizing
// ==============================

// Data path and PC width in bits
`define EX_XLEN 32

// Reservation station / ROB tag width
`define EX_TAG_W 6

// Integer functional units sharing the CDB
`define EX_NUM_FU 3

`endif

//--- cdb_pkg.sv
`default_nettype none

`include "execute_stage_defs.svh"

package cdb_pkg;

    // Machine word, used for operands, results and PCs
    typedef logic [`EX_XLEN-1:0] word_t;

    // Tag of the producing reservation station entry
    typedef logic [`EX_TAG_W-1:0] tag_t;

    // Index of a functional unit on the bus
    typedef logic [$clog2(`EX_NUM_FU)-1:0] fu_idx_t;

    // Result held by one unit until the arbiter grants it
    typedef struct packed {
        tag_t  tag;
        word_t value;
        logic  mispredict;
        word_t correct_pc;
        // Conditional branch outcome for the predictor
        logic  update_predictor;
        // Value is a load/store address
        logic  mem_addr;
    } fu_result_t;

    // One broadcast on the common data bus
    typedef struct packed {
        logic       valid;
        fu_idx_t    src;
        fu_result_t result;
    } cdb_bus_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    // ALU function select, same 4-bit field as the decoder emits
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Branch kind, zero means no branch
    // Six conditional kinds plus JAL and JALR need one bit more than three
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branch_kind_e;

    // Micro-op handed over by a reservation station at issue
    typedef struct packed {
        cdb_pkg::tag_t  tag;
        cdb_pkg::word_t pc;
        cdb_pkg::word_t operand_a;
        cdb_pkg::word_t operand_b;
        alu_op_e        alu_op;
        branch_kind_e   branch_kind;
        logic           predicted_taken;
        // For conditional branches this is the decoded pc-relative target
        cdb_pkg::word_t predicted_target;
        // Write pc+4 as the result (JAL, JALR)
        logic           link;
        logic           is_mem;
    } issue_uop_t;

endpackage

`default_nettype wire

//--- alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_stage_defs.svh"

module alu_shifter (
    input  cdb_pkg::word_t   operand_a,
    input  cdb_pkg::word_t   operand_b,
    input  isa_pkg::alu_op_e alu_op,
    output cdb_pkg::word_t   result,
    output logic             zero,
    output logic             negative,
    output logic             carry
);

    localparam int MSB = `EX_XLEN - 1;

    logic [4:0]        shamt;
    logic [`EX_XLEN:0] add_u;
    logic [`EX_XLEN:0] sub_u;
    logic [`EX_XLEN:0] add_s;
    logic [`EX_XLEN:0] sub_s;

    // Shift amount from the low five bits of B
    assign shamt = operand_b[4:0];

    // Unsigned forms give the carry out
    // Sub carry set means no borrow, so A >= B unsigned
    assign add_u = {1'b0, operand_a} + {1'b0, operand_b};
    assign sub_u = {1'b0, operand_a} + {1'b0, ~operand_b} + 1'b1;

    // Sign-extended forms give the true sign, free of overflow
    assign add_s = {operand_a[MSB], operand_a} + {operand_b[MSB], operand_b};
    assign sub_s = {operand_a[MSB], operand_a} - {operand_b[MSB], operand_b};

    // ==============================
    // Result select
    // ==============================
    always_comb begin
        case (alu_op)
            isa_pkg::ALU_ADD:    result = add_u[MSB:0];
            isa_pkg::ALU_SUB:    result = sub_u[MSB:0];
            isa_pkg::ALU_SLL:    result = operand_a << shamt;
            isa_pkg::ALU_SLT:    result = {{MSB{1'b0}}, sub_s[`EX_XLEN]};
            isa_pkg::ALU_SLTU:   result = {{MSB{1'b0}}, ~sub_u[`EX_XLEN]};
            isa_pkg::ALU_XOR:    result = operand_a ^ operand_b;
            isa_pkg::ALU_SRL:    result = operand_a >> shamt;
            // Arithmetic shift keeps the sign of A
            isa_pkg::ALU_SRA:    result = cdb_pkg::word_t'($signed(operand_a) >>> shamt);
            isa_pkg::ALU_OR:     result = operand_a | operand_b;
            isa_pkg::ALU_AND:    result = operand_a & operand_b;
            isa_pkg::ALU_PASS_B: result = operand_b;
            default:             result = '0;
        endcase
    end

    // ==============================
    // Flags
    // ==============================
    always_comb begin
        zero     = (result == '0);
        negative = result[MSB];
        carry    = 1'b0;
        case (alu_op)
            isa_pkg::ALU_ADD: begin
                negative = add_s[`EX_XLEN];
                carry    = add_u[`EX_XLEN];
            end
            // Compare path for branches, negative is signed A < B
            isa_pkg::ALU_SUB: begin
                negative = sub_s[`EX_XLEN];
                carry    = sub_u[`EX_XLEN];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
    input  isa_pkg::issue_uop_t uop,
    input  cdb_pkg::word_t      alu_result,
    input  logic                zero,
    input  logic                negative,
    input  logic                carry,
    output logic                mispredict,
    output cdb_pkg::word_t      correct_pc,
    output logic                update_predictor
);

    logic           taken;
    cdb_pkg::word_t target;
    cdb_pkg::word_t pc_plus4;

    assign pc_plus4 = uop.pc + cdb_pkg::word_t'(4);

    // Actual direction from the SUB compare flags
    always_comb begin
        case (uop.branch_kind)
            isa_pkg::BR_BEQ:  taken = zero;
            isa_pkg::BR_BNE:  taken = ~zero;
            isa_pkg::BR_BLT:  taken = negative;
            isa_pkg::BR_BGE:  taken = ~negative;
            // Carry set means A >= B unsigned
            isa_pkg::BR_BLTU: taken = ~carry;
            isa_pkg::BR_BGEU: taken = carry;
            isa_pkg::BR_JAL:  taken = 1'b1;
            isa_pkg::BR_JALR: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // Jumps take the ALU sum as target
    // Conditional branches carry their decoded target in the uop
    always_comb begin
        case (uop.branch_kind)
            isa_pkg::BR_JALR: target = alu_result & ~cdb_pkg::word_t'(1);
            isa_pkg::BR_JAL:  target = alu_result;
            default:          target = uop.predicted_target;
        endcase
    end

    // Wrong direction, or right direction with wrong target
    assign mispredict = (taken != uop.predicted_taken) ||
                        (taken && (target != uop.predicted_target));

    assign correct_pc = taken ? target : pc_plus4;

    // Predictor trains on conditional branches only
    assign update_predictor = uop.branch_kind inside {isa_pkg::BR_BEQ, isa_pkg::BR_BNE,
                                                      isa_pkg::BR_BLT, isa_pkg::BR_BGE,
                                                      isa_pkg::BR_BLTU, isa_pkg::BR_BGEU};

endmodule

`default_nettype wire

//--- functional_unit.sv
`timescale 1ns/1ps
`default_nettype none

module functional_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  isa_pkg::issue_uop_t issue_uop,
    output logic                issue_ready,
    output logic                req,
    output cdb_pkg::fu_result_t result,
    input  logic                grant
);

    typedef enum logic {
        IDLE,
        WAIT_GRANT
    } fu_state_e;

    fu_state_e           state;
    fu_state_e           state_next;
    logic                accept;

    cdb_pkg::word_t      alu_result;
    logic                alu_zero;
    logic                alu_negative;
    logic                alu_carry;

    logic                br_mispredict;
    cdb_pkg::word_t      br_correct_pc;
    logic                br_update;

    cdb_pkg::fu_result_t result_next;

    // ==============================
    // Datapath on the incoming uop
    // ==============================
    alu_shifter u_alu (
        .operand_a (issue_uop.operand_a),
        .operand_b (issue_uop.operand_b),
        .alu_op    (issue_uop.alu_op),
        .result    (alu_result),
        .zero      (alu_zero),
        .negative  (alu_negative),
        .carry     (alu_carry)
    );

    branch_resolver u_branch (
        .uop              (issue_uop),
        .alu_result       (alu_result),
        .zero             (alu_zero),
        .negative         (alu_negative),
        .carry            (alu_carry),
        .mispredict       (br_mispredict),
        .correct_pc       (br_correct_pc),
        .update_predictor (br_update)
    );

    // Assemble the broadcast payload
    always_comb begin
        result_next.tag              = issue_uop.tag;
        result_next.mispredict       = br_mispredict;
        result_next.correct_pc       = br_correct_pc;
        result_next.update_predictor = br_update;
        result_next.mem_addr         = issue_uop.is_mem;
        // Link value for jumps
        if (issue_uop.link) begin
            result_next.value = issue_uop.pc + cdb_pkg::word_t'(4);
        // Conditional branches write no register
        end else if (br_update) begin
            result_next.value = '0;
        end else begin
            result_next.value = alu_result;
        end
    end

    // ==============================
    // Issue and bus request control
    // ==============================

    // One uop in flight, ready only when empty
    assign issue_ready = (state == IDLE);
    assign req         = (state == WAIT_GRANT);
    assign accept      = issue_valid && issue_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (accept) state_next = WAIT_GRANT;
            WAIT_GRANT: if (grant) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Result held stable until granted
    always_ff @(posedge clk) begin
        if (accept) begin
            result <= result_next;
        end
    end

endmodule

`default_nettype wire

//--- cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_stage_defs.svh"

module cdb_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`EX_NUM_FU-1:0]  req,
    input  cdb_pkg::fu_result_t    fu_results [`EX_NUM_FU],
    output logic [`EX_NUM_FU-1:0]  grant,
    output cdb_pkg::cdb_bus_t      cdb
);

    // Unit with the highest priority this cycle
    cdb_pkg::fu_idx_t    prio_ptr;
    cdb_pkg::fu_idx_t    win_idx;
    cdb_pkg::fu_idx_t    win_next;
    cdb_pkg::fu_result_t win_result;

    // ==============================
    // Rotating priority grant
    // ==============================
    always_comb begin
        int   idx;
        logic found;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        // Scan from the pointer and wrap once
        for (int i = 0; i < `EX_NUM_FU; i++) begin
            idx = int'(prio_ptr) + i;
            if (idx >= `EX_NUM_FU) begin
                idx = idx - `EX_NUM_FU;
            end
            if (!found && req[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                win_idx    = cdb_pkg::fu_idx_t'(idx);
            end
        end
    end

    assign win_result = fu_results[win_idx];

    // Priority moves to the unit after the winner
    assign win_next = (win_idx == cdb_pkg::fu_idx_t'(`EX_NUM_FU - 1)) ?
                      '0 : cdb_pkg::fu_idx_t'(win_idx + 1'b1);

    // ==============================
    // Registered CDB driver
    // ==============================
    always_ff @(posedge clk) begin
        cdb.src    <= win_idx;
        cdb.result <= win_result;
        if (!rst_n) begin
            cdb.valid <= 1'b0;
            prio_ptr  <= '0;
        end else begin
            // One pulse per grant, no back-pressure
            cdb.valid <= |req;
            if (|req) begin
                prio_ptr <= win_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_stage_defs.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,

    // Issue ports from the reservation stations
    input  logic [`EX_NUM_FU-1:0] issue_valid,
    input  isa_pkg::issue_uop_t   issue_uop [`EX_NUM_FU],
    output logic [`EX_NUM_FU-1:0] issue_ready,

    // Common data bus broadcast
    output cdb_pkg::cdb_bus_t     cdb
);

    // ==============================
    // Unit to arbiter wiring
    // ==============================
    logic [`EX_NUM_FU-1:0] fu_req;
    logic [`EX_NUM_FU-1:0] fu_grant;
    cdb_pkg::fu_result_t   fu_result [`EX_NUM_FU];

    // ==============================
    // Integer functional units
    // ==============================

    // Identical peers, each with its own issue port
    for (genvar i = 0; i < `EX_NUM_FU; i++) begin : g_fu
        functional_unit u_fu (
            .clk         (clk),
            .rst_n       (rst_n),
            .issue_valid (issue_valid[i]),
            .issue_uop   (issue_uop[i]),
            .issue_ready (issue_ready[i]),
            .req         (fu_req[i]),
            .result      (fu_result[i]),
            .grant       (fu_grant[i])
        );
    end

    // ==============================
    // CDB arbitration
    // ==============================

    // Single winner per cycle, broadcast one cycle later
    cdb_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (fu_req),
        .fu_results (fu_result),
        .grant      (fu_grant),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

//--- execute_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_stage_defs.svh"

module execute_stage_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`EX_NUM_FU-1:0] issue_valid,
    input logic [`EX_NUM_FU-1:0] issue_ready,
    input logic [`EX_NUM_FU-1:0] fu_req,
    input logic [`EX_NUM_FU-1:0] fu_grant,
    input cdb_pkg::cdb_bus_t     cdb
);

    // Units that take a uop this cycle or still wait for the CDB
    logic [`EX_NUM_FU-1:0] held;

    assign held = (issue_valid & issue_ready) | (~issue_ready & ~fu_grant);

    // ==============================
    // Arbiter grant rules
    // ==============================

    // At most one winner per cycle
    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(fu_grant))
        else $error("CDB grant has more than one bit set");

    // Only a requesting unit can win
    grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        (fu_grant & ~fu_req) == '0)
        else $error("CDB grant given to a unit without a request");

    // ==============================
    // CDB pulse timing
    // ==============================
    grant_then_cdb: assert property (@(posedge clk) disable iff (!rst_n)
        |fu_grant |=> cdb.valid)
        else $error("grant not followed by a CDB pulse");

    cdb_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
        cdb.valid |-> $past(|fu_grant))
        else $error("CDB pulse without a grant one cycle before");

    // A unit that took a uop stays not ready until it wins the CDB
    wait_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_ready & $past(held)) == '0)
        else $error("unit holding a result still reports issue ready");

    // One reset edge brings the stage to its idle state
    reset_state: assert property (@(posedge clk)
        !rst_n |=> (!cdb.valid && (issue_ready == '1) && (fu_req == '0)))
        else $error("stage not idle after reset");

endmodule

// Attach to every execute stage instance
bind execute_stage execute_stage_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .fu_req      (fu_req),
    .fu_grant    (fu_grant),
    .cdb         (cdb)
);

`default_nettype wire

//--- tb_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_stage_defs.svh"

module tb_execute_stage;

    localparam int NFU     = `EX_NUM_FU;
    localparam int MAX_VEC = 64;
    localparam int NTAG    = 2 ** `EX_TAG_W;

    logic                clk;
    logic                rst_n;
    logic [NFU-1:0]      issue_valid;
    isa_pkg::issue_uop_t issue_uop [NFU];
    logic [NFU-1:0]      issue_ready;
    cdb_pkg::cdb_bus_t   cdb;

    // Raw vector columns in file order
    logic [31:0]         vec [MAX_VEC][17];
    int                  num_vec;
    logic                loaded;

    // Scoreboard, vector index of each tag in flight or -1
    int                  vec_of_tag [NTAG];
    logic [NFU-1:0]      busy;
    int                  outstanding;
    int                  seen;
    // Model of the rotating priority pointer
    int                  rr_ptr;
    int                  group_cyc;
    int                  group_pulses;
    int                  cyc;
    integer              seed;

    execute_stage dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issue_ready (issue_ready),
        .cdb         (cdb)
    );

    // ==============================
    // Clock and cycle count
    // ==============================
    initial clk = 1'b0;
    always #50 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        integer fd;
        integer n;
        string  line;
        fd = $fopen("execute_stage_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open execute_stage_vectors.txt");
        end
        num_vec = 0;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            n = $fgets(line, fd);
            // Skip comment and blank lines
            if (n < 8 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[num_vec][0], vec[num_vec][1], vec[num_vec][2], vec[num_vec][3],
                        vec[num_vec][4], vec[num_vec][5], vec[num_vec][6], vec[num_vec][7],
                        vec[num_vec][8], vec[num_vec][9], vec[num_vec][10], vec[num_vec][11],
                        vec[num_vec][12], vec[num_vec][13], vec[num_vec][14],
                        vec[num_vec][15], vec[num_vec][16]);
            if (n != 17 || vec[num_vec][1] >= NFU) begin
                abort_run("malformed line in the vector file");
            end
            num_vec++;
        end
        $fclose(fd);
    endtask

    // Drive one uop onto its unit's issue port
    task automatic issue_one(input int v);
        int u;
        int t;
        u = int'(vec[v][1]);
        t = int'(vec[v][2]);
        if (vec_of_tag[t] >= 0 || busy[u]) begin
            abort_run("vector group reuses a tag or a unit that is not free");
        end
        // An empty unit offers ready
        check_value("issue_ready", 32'(issue_ready[u]), 32'(1));
        issue_uop[u].tag              = cdb_pkg::tag_t'(vec[v][2]);
        issue_uop[u].pc               = vec[v][3];
        issue_uop[u].operand_a        = vec[v][4];
        issue_uop[u].operand_b        = vec[v][5];
        issue_uop[u].alu_op           = isa_pkg::alu_op_e'(vec[v][6][3:0]);
        issue_uop[u].branch_kind      = isa_pkg::branch_kind_e'(vec[v][7][3:0]);
        issue_uop[u].predicted_taken  = vec[v][8][0];
        issue_uop[u].predicted_target = vec[v][9];
        issue_uop[u].link             = vec[v][10][0];
        issue_uop[u].is_mem           = vec[v][11][0];
        issue_valid[u]                = 1'b1;
        vec_of_tag[t]                 = v;
        busy[u]                       = 1'b1;
        outstanding++;
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int v;
        int first;
        int gap;
        rst_n        = 1'b0;
        issue_valid  = '0;
        busy         = '0;
        outstanding  = 0;
        seen         = 0;
        rr_ptr       = 0;
        group_cyc    = 0;
        group_pulses = 0;
        cyc          = 0;
        seed         = 42795;
        loaded       = 1'b0;
        for (int k = 0; k < NFU; k++) begin
            issue_uop[k] = '0;
        end
        for (int k = 0; k < NTAG; k++) begin
            vec_of_tag[k] = -1;
        end
        load_vectors();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        v = 0;
        while (v < num_vec) begin
            // Each group starts on an empty stage
            @(posedge clk);
            while (outstanding != 0) begin
                @(posedge clk);
            end
            gap = {$random(seed)} % 4;
            repeat (gap) @(posedge clk);
            @(negedge clk);
            first        = v;
            group_cyc    = cyc;
            group_pulses = 0;
            // Lines sharing a group number issue in the same cycle
            while (v < num_vec && vec[v][0] == vec[first][0]) begin
                issue_one(v);
                v++;
            end
            @(negedge clk);
            issue_valid = '0;
        end
        @(posedge clk);
        while (outstanding != 0) begin
            @(posedge clk);
        end
        // Room for a duplicate broadcast to show up
        repeat (3) @(posedge clk);
        if (seen == num_vec && num_vec > 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("run ended before every tag was broadcast");
        end
    end

    // ==============================
    // CDB scoreboard
    // ==============================
    always @(negedge clk) begin
        int             t;
        int             v;
        int             want;
        logic [NFU-1:0] idle_units;
        if (rst_n && cdb.valid) begin
            t = int'(cdb.result.tag);
            v = vec_of_tag[t];
            if (v < 0) begin
                abort_run($sformatf("CDB carries tag %0h which is not in flight", t));
            end
            // First busy unit at or after the pointer, scanned downward
            want = -1;
            for (int k = NFU - 1; k >= 0; k--) begin
                if (busy[(rr_ptr + k) % NFU]) want = (rr_ptr + k) % NFU;
            end
            check_value("cdb.src", 32'(cdb.src), 32'(want));
            check_value("cdb.src unit", 32'(cdb.src), vec[v][1]);
            check_value("cdb.value", cdb.result.value, vec[v][12]);
            check_value("cdb.mispredict", 32'(cdb.result.mispredict), vec[v][13]);
            check_value("cdb.correct_pc", cdb.result.correct_pc, vec[v][14]);
            check_value("cdb.update_predictor", 32'(cdb.result.update_predictor), vec[v][15]);
            check_value("cdb.mem_addr", 32'(cdb.result.mem_addr), vec[v][16]);
            // Two cycles alone, one more per earlier winner of the group
            check_value("cdb latency", 32'(cyc - group_cyc), 32'(2 + group_pulses));
            vec_of_tag[t] = -1;
            busy[cdb.src] = 1'b0;
            // Released unit is ready again, the others still wait
            idle_units = ~busy;
            check_value("issue_ready", 32'(issue_ready), 32'(idle_units));
            rr_ptr        = (int'(cdb.src) + 1) % NFU;
            outstanding--;
            seen++;
            group_pulses++;
        end
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        repeat (num_vec * 10 + 8) @(posedge clk);
        abort_run("watchdog timeout, CDB broadcasts did not complete");
    end

endmodule

`default_nettype wire

//--- execute_stage_vectors.txt
# grp unit tag pc a b alu_op branch_kind pred_taken pred_target link is_mem
# then expected: value mispredict correct_pc update_predictor mem_addr (all hex)
00 0 01 00001000 00000005 00000007 0 0 0 00000000 0 0 0000000c 0 00001004 0 0
01 1 02 00001004 00000005 00000007 1 0 0 00000000 0 0 fffffffe 0 00001008 0 0
02 2 03 00001008 00000001 00000024 2 0 0 00000000 0 0 00000010 0 0000100c 0 0
03 0 04 0000100c fffffff0 00000001 3 0 0 00000000 0 0 00000001 0 00001010 0 0
04 0 05 00001010 fffffff0 00000001 4 0 0 00000000 0 0 00000000 0 00001014 0 0
04 1 06 00001014 0f0f0f0f ffff0000 5 0 0 00000000 0 0 f0f00f0f 0 00001018 0 0
04 2 07 00001018 80000000 00000004 6 0 0 00000000 0 0 08000000 0 0000101c 0 0
05 1 08 0000101c 80000010 00000004 7 0 0 00000000 0 0 f8000001 0 00001020 0 0
06 2 09 00001020 f0000000 0000001f 7 0 0 00000000 0 0 ffffffff 0 00001024 0 0
07 0 0a 00001024 00ff00f0 0f000f0f 8 0 0 00000000 0 0 0fff0fff 0 00001028 0 0
07 1 0b 00001028 00ff00f0 0f0f0f0f 9 0 0 00000000 0 0 000f0000 0 0000102c 0 0
08 2 0c 0000102c 12345678 deadbeef a 0 0 00000000 0 0 deadbeef 0 00001030 0 0
09 0 0d 00001030 00002000 fffffffc 0 0 0 00000000 0 1 00001ffc 0 00001034 0 1
09 1 0e 00001034 00000001 fffffff0 4 0 0 00000000 0 0 00000001 0 00001038 0 0
0a 0 0f 00002000 00000005 00000005 1 1 1 00002040 0 0 00000000 0 00002040 1 0
0a 1 10 00002004 00000005 00000006 1 1 1 00002080 0 0 00000000 1 00002008 1 0
0a 2 11 00002008 00000005 00000006 1 2 0 00002100 0 0 00000000 1 00002100 1 0
0b 0 12 0000200c fffffffe 00000003 1 3 1 00001f00 0 0 00000000 0 00001f00 1 0
0c 1 13 00002010 7fffffff 80000000 1 3 1 00002200 0 0 00000000 1 00002014 1 0
0c 2 14 00002014 80000000 7fffffff 1 4 0 00002300 0 0 00000000 0 00002018 1 0
0d 0 15 00002018 ffffffff 00000001 1 5 0 00002400 0 0 00000000 0 0000201c 1 0
0d 1 16 0000201c 00000001 ffffffff 1 5 0 00002500 0 0 00000000 1 00002500 1 0
0e 2 17 00002020 ffffffff ffffffff 1 6 1 00002600 0 0 00000000 0 00002600 1 0
0e 0 18 00002024 00000002 00000003 1 6 1 00002700 0 0 00000000 1 00002028 1 0
0f 1 19 00003000 00003000 00000100 0 7 1 00003100 1 0 00003004 0 00003100 0 0
10 2 1a 00003004 00004001 00000010 0 8 1 00004010 1 0 00003008 0 00004010 0 0
10 0 1b 00003008 00005000 00000023 0 8 1 00005000 1 0 0000300c 1 00005022 0 0
11 0 1c 0000300c 00000003 00000004 0 0 0 00000000 0 0 00000007 0 00003010 0 0
11 1 1d 00003010 00006000 00000008 0 0 0 00000000 0 1 00006008 0 00003014 0 1
11 2 1e 00003014 00000010 00000011 1 2 0 00003050 0 0 00000000 1 00003050 1 0

//--- execute_stage.f
+incdir+.
cdb_pkg.sv
isa_pkg.sv
alu_shifter.sv
branch_resolver.sv
functional_unit.sv
cdb_arbiter.sv
execute_stage.sv
execute_stage_sva.sv
tb_execute_stage.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the execute stage testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_execute_stage \
    -f execute_stage.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_execute_stage > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
